/* flash_emu_config.svh */
// build-time sizes for the flash emulator
// address width, image size, memory read latency
// and depth of the log and reply FIFOs
`ifndef FLASH_EMU_CONFIG_SVH
`define FLASH_EMU_CONFIG_SVH

// address bits seen by both requesters
`define FE_ADDR_W 16

// image size in bytes, addresses wrap here
`define FE_MEM_WORDS 65536

// cycles from read grant to ack
`define FE_READ_LAT 2

// entries in each event FIFO
`define FE_FIFO_DEPTH 4

`endif

/* spi_flash_pkg.sv */
// SPI side definitions
// opcodes answered by the flash target
// JEDEC ID bytes and the read log record
package spi_flash_pkg;

	// only the plain read and the id read are decoded
	typedef enum logic [7:0] {
		OP_READ     = 8'h03,
		OP_JEDEC_ID = 8'h9F
	} opcode_e;

	// manufacturer, memory type, capacity
	localparam logic [23:0] JEDEC_ID = 24'hEF_40_18;

	// one record per SPI read transaction
	// len saturates at 255
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  len;
	} log_rec_t;

endpackage

/* host_pkg.sv */
// host side definitions
// command bytes, frame markers, requester tag
package host_pkg;

	// ascii command letters on the host receive port
	typedef enum logic [7:0] {
		CMD_WRITE = 8'h57,
		CMD_READ  = 8'h52
	} host_cmd_e;

	// first byte of each host transmit frame
	localparam logic [7:0] MARK_LOG  = 8'h4C;
	localparam logic [7:0] MARK_READ = 8'h44;

	// tags a memory access with its owner
	typedef enum logic {
		SRC_SPI  = 1'b0,
		SRC_HOST = 1'b1
	} req_src_e;

endpackage

/* event_fifo.sv */
// synchronous FIFO with a typed payload
// used for SPI log records and host reply bytes
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module event_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = `FE_FIFO_DEPTH
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push_i,
	input  payload_t data_i,
	input  logic     pop_i,
	output payload_t data_o,
	output logic     empty_o,
	output logic     full_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = PTR_W + 1;

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// a push into a full buffer is lost
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;
	assign empty_o = (count == '0);
	assign full_o = (count == CNT_W'(DEPTH));
	// head entry is always visible
	assign data_o = mem[rd_ptr];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop keeps the level
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= data_i;
	end

endmodule

/* spi_flash_target.sv */
// SPI mode 0 flash target, oversampled on clk
// decodes read 0x03 and JEDEC id 0x9F
// prefetches read bytes from the shared memory
// emits a log record when a read ends
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module spi_flash_target (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  spi_cs_n_i,
	input  logic                  spi_sclk_i,
	input  logic                  spi_mosi_i,
	output logic                  spi_miso_o,
	output logic                  mem_req_o,
	output logic [`FE_ADDR_W-1:0] mem_addr_o,
	input  logic                  mem_ack_i,
	input  logic [7:0]            mem_rdata_i,
	output logic                  log_push_o,
	output spi_flash_pkg::log_rec_t log_rec_o
);
	////////////////////
	// pin synchronizers and edge detect
	////////////////////
	logic [2:0] cs_sr;
	logic [2:0] sclk_sr;
	logic [1:0] mosi_sr;
	logic cs_n;
	logic cs_rise;
	logic sclk_rise;
	logic sclk_fall;
	logic byte_done;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cs_sr <= '1;
			sclk_sr <= '0;
			mosi_sr <= '0;
		end
		else
		begin
			cs_sr <= {cs_sr[1:0], spi_cs_n_i};
			sclk_sr <= {sclk_sr[1:0], spi_sclk_i};
			mosi_sr <= {mosi_sr[0], spi_mosi_i};
		end
	end

	assign cs_n = cs_sr[1];
	assign cs_rise = cs_sr[1] && !cs_sr[2];
	// sclk edges only count while selected
	assign sclk_rise = sclk_sr[1] && !sclk_sr[2] && !cs_n;
	assign sclk_fall = !sclk_sr[1] && sclk_sr[2] && !cs_n;

	////////////////////
	// command decode and shifters
	////////////////////
	spi_flash_pkg::opcode_e opcode;
	logic [6:0] rx_shift;
	logic [7:0] rx_byte;
	logic [7:0] tx_shift;
	logic [7:0] next_byte;
	logic [7:0] id_byte;
	logic [7:0] rd_count;
	logic [2:0] bit_cnt;
	// 0 opcode, 1..3 address, 4 data
	logic [2:0] byte_idx;
	logic [1:0] id_idx;
	logic [`FE_ADDR_W-1:0] addr_acc;
	logic [`FE_ADDR_W-1:0] addr_full;
	logic [`FE_ADDR_W-1:0] start_addr;
	logic is_read;

	assign rx_byte = {rx_shift, mosi_sr[1]};
	assign byte_done = sclk_rise && (bit_cnt == 3'd7);
	assign is_read = (opcode == spi_flash_pkg::OP_READ);
	// only the low address bits reach the array
	assign addr_full = {addr_acc[`FE_ADDR_W-9:0], rx_byte};
	assign spi_miso_o = tx_shift[7];

	// id bytes after the first one, zeros once exhausted
	always_comb
	begin
		case (id_idx)
			2'd1: id_byte = spi_flash_pkg::JEDEC_ID[15:8];
			2'd2: id_byte = spi_flash_pkg::JEDEC_ID[7:0];
			default: id_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			opcode <= spi_flash_pkg::opcode_e'(8'h00);
			rx_shift <= '0;
			tx_shift <= '0;
			next_byte <= '0;
			rd_count <= '0;
			bit_cnt <= '0;
			byte_idx <= '0;
			id_idx <= '0;
			addr_acc <= '0;
			start_addr <= '0;
			mem_req_o <= 1'b0;
			mem_addr_o <= '0;
			log_push_o <= 1'b0;
			log_rec_o <= '0;
		end
		else
		begin
			// record goes out the cycle after cs rises, empty reads log nothing
			log_push_o <= cs_rise && is_read && (rd_count != 8'd0);
			log_rec_o <= '{addr: start_addr, len: rd_count};

			// fetched byte waits here until its first falling edge
			if (mem_req_o && mem_ack_i)
			begin
				mem_req_o <= 1'b0;
				next_byte <= mem_rdata_i;
			end

			if (cs_n)
			begin
				opcode <= spi_flash_pkg::opcode_e'(8'h00);
				tx_shift <= '0;
				rd_count <= '0;
				bit_cnt <= '0;
				byte_idx <= '0;
				id_idx <= '0;
			end
			else if (sclk_rise)
			begin
				rx_shift <= rx_byte[6:0];
				bit_cnt <= bit_cnt + 3'd1;
				if (byte_done)
				begin
					if (byte_idx != 3'd4)
						byte_idx <= byte_idx + 3'd1;
					case (byte_idx)
						3'd0:
						begin
							opcode <= spi_flash_pkg::opcode_e'(rx_byte);
							// id answer starts right after the opcode
							if (rx_byte == spi_flash_pkg::OP_JEDEC_ID)
								next_byte <= spi_flash_pkg::JEDEC_ID[23:16];
							else
								next_byte <= 8'h00;
							id_idx <= 2'd1;
						end
						3'd1, 3'd2:
							addr_acc <= addr_full;
						3'd3:
						begin
							addr_acc <= addr_full;
							// first data byte fetch
							if (is_read)
							begin
								mem_addr_o <= addr_full;
								start_addr <= addr_full;
								mem_req_o <= 1'b1;
							end
						end
						default:
						begin
							if (is_read && rd_count != 8'hFF)
								rd_count <= rd_count + 8'd1;
						end
					endcase
					if (byte_idx != 3'd0 && opcode == spi_flash_pkg::OP_JEDEC_ID)
					begin
						next_byte <= id_byte;
						if (id_idx != 2'd3)
							id_idx <= id_idx + 2'd1;
					end
				end
			end
			else if (sclk_fall)
			begin
				if (bit_cnt == 3'd0)
				begin
					// byte boundary, msb goes out now
					tx_shift <= next_byte;
					// prefetch the following address while this byte shifts
					if (is_read && byte_idx == 3'd4)
					begin
						mem_addr_o <= (mem_addr_o == `FE_ADDR_W'(`FE_MEM_WORDS - 1)) ?
							'0 : mem_addr_o + 1'b1;
						mem_req_o <= 1'b1;
					end
				end
				else
					tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

endmodule

/* host_cmd_parser.sv */
// host command parser
// collects W and R commands byte by byte
// drives one memory access per command
// read data goes to the reply FIFO
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module host_cmd_parser (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [7:0]            host_rx_data_i,
	input  logic                  host_rx_valid_i,
	output logic                  mem_req_o,
	output logic                  mem_we_o,
	output logic [`FE_ADDR_W-1:0] mem_addr_o,
	output logic [7:0]            mem_wdata_o,
	input  logic                  mem_ack_i,
	input  logic [7:0]            mem_rdata_i,
	output logic                  reply_push_o,
	output logic [7:0]            reply_data_o,
	input  logic                  reply_full_i
);
	typedef enum logic [2:0] {
		ST_CMD,
		ST_ADDR_HI,
		ST_ADDR_LO,
		ST_DATA,
		ST_ROOM,
		ST_MEM
	} state_e;

	state_e state;
	logic [7:0] addr_hi;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_CMD;
			addr_hi <= '0;
			mem_req_o <= 1'b0;
			mem_we_o <= 1'b0;
			mem_addr_o <= '0;
			mem_wdata_o <= '0;
			reply_push_o <= 1'b0;
			reply_data_o <= '0;
		end
		else
		begin
			reply_push_o <= 1'b0;
			case (state)
				ST_CMD:
				begin
					// unknown letters are skipped
					if (host_rx_valid_i && (host_rx_data_i == host_pkg::CMD_WRITE ||
						host_rx_data_i == host_pkg::CMD_READ))
					begin
						mem_we_o <= (host_rx_data_i == host_pkg::CMD_WRITE);
						state <= ST_ADDR_HI;
					end
				end
				ST_ADDR_HI:
				begin
					if (host_rx_valid_i)
					begin
						addr_hi <= host_rx_data_i;
						state <= ST_ADDR_LO;
					end
				end
				ST_ADDR_LO:
				begin
					if (host_rx_valid_i)
					begin
						mem_addr_o <= `FE_ADDR_W'({addr_hi, host_rx_data_i});
						state <= mem_we_o ? ST_DATA : ST_ROOM;
					end
				end
				ST_DATA:
				begin
					if (host_rx_valid_i)
					begin
						mem_wdata_o <= host_rx_data_i;
						mem_req_o <= 1'b1;
						state <= ST_MEM;
					end
				end
				// read waits for reply space so the push cannot be lost
				ST_ROOM:
				begin
					if (!reply_full_i)
					begin
						mem_req_o <= 1'b1;
						state <= ST_MEM;
					end
				end
				ST_MEM:
				begin
					if (mem_ack_i)
					begin
						mem_req_o <= 1'b0;
						reply_push_o <= !mem_we_o;
						reply_data_o <= mem_rdata_i;
						state <= ST_CMD;
					end
				end
				default:
					state <= ST_CMD;
			endcase
		end
	end

endmodule

/* shared_flash_mem.sv */
// flash image store shared by SPI and host
// one grant per cycle, SPI owns it while cs is low
// read latency pipeline tagged by requester
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module shared_flash_mem (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  spi_cs_n_i,
	input  logic                  spi_req_i,
	input  logic [`FE_ADDR_W-1:0] spi_addr_i,
	output logic                  spi_ack_o,
	output logic [7:0]            spi_rdata_o,
	input  logic                  host_req_i,
	input  logic                  host_we_i,
	input  logic [`FE_ADDR_W-1:0] host_addr_i,
	input  logic [7:0]            host_wdata_i,
	output logic                  host_ack_o,
	output logic [7:0]            host_rdata_o
);
	localparam int LAT = `FE_READ_LAT;

	logic [7:0] mem [`FE_MEM_WORDS];
	logic [1:0] cs_sync;
	logic spi_busy;
	logic host_busy;
	logic pick_spi;
	logic pick_host;

	// grant register, the access happens in the grant cycle
	logic gnt_valid;
	logic gnt_we;
	host_pkg::req_src_e gnt_src;
	logic [`FE_ADDR_W-1:0] gnt_addr;
	logic [7:0] gnt_wdata;
	logic wr_ack;

	logic [LAT-1:0] pipe_vld;
	host_pkg::req_src_e pipe_src [LAT];
	logic [7:0] pipe_data [LAT];

	// a request already granted is not picked again
	assign pick_spi = spi_req_i && !spi_busy;
	// host waits while the SPI transaction is open, SPI wins ties
	assign pick_host = host_req_i && !host_busy && cs_sync[1] && !pick_spi;

	assign spi_ack_o = pipe_vld[LAT-1] && (pipe_src[LAT-1] == host_pkg::SRC_SPI);
	assign host_ack_o = wr_ack ||
		(pipe_vld[LAT-1] && (pipe_src[LAT-1] == host_pkg::SRC_HOST));
	assign spi_rdata_o = pipe_data[LAT-1];
	assign host_rdata_o = pipe_data[LAT-1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cs_sync <= '1;
			spi_busy <= 1'b0;
			host_busy <= 1'b0;
			gnt_valid <= 1'b0;
			wr_ack <= 1'b0;
			pipe_vld <= '0;
		end
		else
		begin
			cs_sync <= {cs_sync[0], spi_cs_n_i};
			gnt_valid <= pick_spi || pick_host;
			spi_busy <= pick_spi || (spi_busy && !spi_ack_o);
			host_busy <= pick_host || (host_busy && !host_ack_o);
			// writes finish one cycle after the grant
			wr_ack <= gnt_valid && gnt_we;
			pipe_vld <= {pipe_vld[LAT-2:0], gnt_valid && !gnt_we};
		end
	end

	always_ff @(posedge clk)
	begin
		gnt_src <= pick_spi ? host_pkg::SRC_SPI : host_pkg::SRC_HOST;
		gnt_addr <= pick_spi ? spi_addr_i : host_addr_i;
		gnt_we <= pick_host && host_we_i;
		gnt_wdata <= host_wdata_i;
		if (gnt_valid && gnt_we)
			mem[gnt_addr] <= gnt_wdata;
		// stage 0 is the array read itself
		pipe_src[0] <= gnt_src;
		pipe_data[0] <= mem[gnt_addr];
		for (int i = 1; i < LAT; i++)
		begin
			pipe_src[i] <= pipe_src[i-1];
			pipe_data[i] <= pipe_data[i-1];
		end
	end

endmodule

/* host_tx_merge.sv */
// host transmit merger
// D frames from the reply FIFO, L frames from the log FIFO
// one byte per ready cycle, frames never interleave
`timescale 1ns/100ps

module host_tx_merge (
	input  logic       clk,
	input  logic       reset,
	input  logic       reply_empty_i,
	input  logic [7:0] reply_data_i,
	output logic       reply_pop_o,
	input  logic       log_empty_i,
	input  spi_flash_pkg::log_rec_t log_rec_i,
	output logic       log_pop_o,
	input  logic       host_tx_ready_i,
	output logic [7:0] host_tx_data_o,
	output logic       host_tx_valid_o
);
	// frame bytes, next one to send in the top byte
	logic [31:0] frame_buf;
	// bytes left in the current frame, zero when idle
	logic [2:0] left;

	// a pending reply always beats a pending log record
	assign reply_pop_o = (left == 3'd0) && !reply_empty_i;
	assign log_pop_o = (left == 3'd0) && reply_empty_i && !log_empty_i;

	// valid only where ready is seen, the byte holds otherwise
	assign host_tx_valid_o = (left != 3'd0) && host_tx_ready_i;
	assign host_tx_data_o = frame_buf[31:24];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			frame_buf <= '0;
			left <= '0;
		end
		else if (reply_pop_o)
		begin
			frame_buf <= {host_pkg::MARK_READ, reply_data_i, 16'h0000};
			left <= 3'd2;
		end
		else if (log_pop_o)
		begin
			// marker, address high, address low, length
			frame_buf <= {host_pkg::MARK_LOG, log_rec_i};
			left <= 3'd4;
		end
		else if (host_tx_valid_o)
		begin
			frame_buf <= {frame_buf[23:0], 8'h00};
			left <= left - 3'd1;
		end
	end

endmodule

/* flash_emu_top.sv */
// flash emulator top level
// SPI target and host parser share one image store
// log records and reply bytes merge onto the host port
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module flash_emu_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       spi_cs_n_i,
	input  logic       spi_sclk_i,
	input  logic       spi_mosi_i,
	output logic       spi_miso_o,
	input  logic [7:0] host_rx_data_i,
	input  logic       host_rx_valid_i,
	input  logic       host_tx_ready_i,
	output logic [7:0] host_tx_data_o,
	output logic       host_tx_valid_o
);
	// SPI requester
	logic spi_req;
	logic spi_ack;
	logic [`FE_ADDR_W-1:0] spi_addr;
	logic [7:0] spi_rdata;

	// host requester
	logic host_req;
	logic host_we;
	logic host_ack;
	logic [`FE_ADDR_W-1:0] host_addr;
	logic [7:0] host_wdata;
	logic [7:0] host_rdata;

	// log records towards the merger
	logic log_push;
	logic log_pop;
	logic log_empty;
	spi_flash_pkg::log_rec_t log_rec_in;
	spi_flash_pkg::log_rec_t log_rec_out;

	// reply bytes towards the merger
	logic reply_push;
	logic reply_pop;
	logic reply_empty;
	logic reply_full;
	logic [7:0] reply_in;
	logic [7:0] reply_out;

	spi_flash_target target0 (
		.clk(clk), .reset(reset),
		.spi_cs_n_i(spi_cs_n_i), .spi_sclk_i(spi_sclk_i),
		.spi_mosi_i(spi_mosi_i), .spi_miso_o(spi_miso_o),
		.mem_req_o(spi_req), .mem_addr_o(spi_addr),
		.mem_ack_i(spi_ack), .mem_rdata_i(spi_rdata),
		.log_push_o(log_push), .log_rec_o(log_rec_in)
	);

	host_cmd_parser parser0 (
		.clk(clk), .reset(reset),
		.host_rx_data_i(host_rx_data_i), .host_rx_valid_i(host_rx_valid_i),
		.mem_req_o(host_req), .mem_we_o(host_we),
		.mem_addr_o(host_addr), .mem_wdata_o(host_wdata),
		.mem_ack_i(host_ack), .mem_rdata_i(host_rdata),
		.reply_push_o(reply_push), .reply_data_o(reply_in),
		.reply_full_i(reply_full)
	);

	shared_flash_mem mem0 (
		.clk(clk), .reset(reset), .spi_cs_n_i(spi_cs_n_i),
		.spi_req_i(spi_req), .spi_addr_i(spi_addr),
		.spi_ack_o(spi_ack), .spi_rdata_o(spi_rdata),
		.host_req_i(host_req), .host_we_i(host_we),
		.host_addr_i(host_addr), .host_wdata_i(host_wdata),
		.host_ack_o(host_ack), .host_rdata_o(host_rdata)
	);

	// a record arriving on a full FIFO is dropped
	event_fifo #(
		.payload_t(spi_flash_pkg::log_rec_t),
		.DEPTH(`FE_FIFO_DEPTH)
	) log_fifo0 (
		.clk(clk), .reset(reset),
		.push_i(log_push), .data_i(log_rec_in),
		.pop_i(log_pop), .data_o(log_rec_out),
		.empty_o(log_empty), .full_o()
	);

	event_fifo #(
		.payload_t(logic [7:0]),
		.DEPTH(`FE_FIFO_DEPTH)
	) reply_fifo0 (
		.clk(clk), .reset(reset),
		.push_i(reply_push), .data_i(reply_in),
		.pop_i(reply_pop), .data_o(reply_out),
		.empty_o(reply_empty), .full_o(reply_full)
	);

	host_tx_merge merge0 (
		.clk(clk), .reset(reset),
		.reply_empty_i(reply_empty), .reply_data_i(reply_out),
		.reply_pop_o(reply_pop),
		.log_empty_i(log_empty), .log_rec_i(log_rec_out),
		.log_pop_o(log_pop),
		.host_tx_ready_i(host_tx_ready_i),
		.host_tx_data_o(host_tx_data_o),
		.host_tx_valid_o(host_tx_valid_o)
	);

endmodule

/* flash_emu_checker.sv */
// checker for the flash emulator
// decodes host receive and SPI pins into a shadow image
// expected D and L frames are compared against host transmit
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module flash_emu_checker (
	input  logic       clk,
	input  logic       reset,
	input  logic       quiet_i,
	input  logic       spi_cs_n_i,
	input  logic       spi_sclk_i,
	input  logic       spi_mosi_i,
	input  logic       spi_miso_i,
	input  logic [7:0] host_rx_data_i,
	input  logic       host_rx_valid_i,
	input  logic [7:0] host_tx_data_i,
	input  logic       host_tx_valid_i,
	output int         errors_o,
	output int         checks_o,
	output int         pending_o
);
	logic [7:0] shadow [`FE_MEM_WORDS];
	bit known [`FE_MEM_WORDS];
	// expected payload bytes, markers excluded
	logic [7:0] d_q [$];
	logic [7:0] l_q [$];

	// host receive decode
	int rx_idx = 0;
	logic [7:0] rx_cmd;
	logic [15:0] rx_addr;

	// SPI decode
	logic sclk_q = 1'b0;
	logic cs_q = 1'b1;
	logic [7:0] mosi_sh;
	logic [7:0] miso_sh;
	logic [7:0] op = 8'h00;
	logic [15:0] spi_addr;
	int bit_n = 0;
	int byte_n = 0;
	int data_n = 0;

	// host transmit frame tracking
	int tx_left = 0;
	logic [7:0] tx_mark;

	int errors = 0;
	int checks = 0;

	assign errors_o = errors;
	assign checks_o = checks;

	task automatic report(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic compare(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp)
			report($sformatf("%s got %02h expected %02h", what, got, exp));
	endtask

	always @(posedge clk)
	begin
		logic [7:0] mbyte;
		logic [7:0] sbyte;
		logic [7:0] exp;
		int a;
		if (reset)
		begin
			rx_idx = 0;
			tx_left = 0;
			sclk_q = 1'b0;
			cs_q = 1'b1;
		end
		else
		begin
			// nothing may leave the DUT before stimulus starts
			if (quiet_i && (host_tx_valid_i || spi_miso_i))
				report("output active before any stimulus");

			////////////////////
			// host receive
			////////////////////
			if (host_rx_valid_i)
			begin
				case (rx_idx)
					0:
					begin
						if (host_rx_data_i == host_pkg::CMD_WRITE ||
							host_rx_data_i == host_pkg::CMD_READ)
						begin
							rx_cmd = host_rx_data_i;
							rx_idx = 1;
						end
					end
					1:
					begin
						rx_addr[15:8] = host_rx_data_i;
						rx_idx = 2;
					end
					2:
					begin
						rx_addr[7:0] = host_rx_data_i;
						rx_idx = (rx_cmd == host_pkg::CMD_WRITE) ? 3 : 0;
						// read reply is fixed by the image at command time
						if (rx_cmd == host_pkg::CMD_READ)
						begin
							if (!known[rx_addr])
								report($sformatf("host read of unwritten address %04h",
									rx_addr));
							d_q.push_back(shadow[rx_addr]);
						end
					end
					default:
					begin
						shadow[rx_addr] = host_rx_data_i;
						known[rx_addr] = 1'b1;
						rx_idx = 0;
					end
				endcase
			end

			////////////////////
			// host transmit
			////////////////////
			if (host_tx_valid_i)
			begin
				if (tx_left == 0)
				begin
					checks++;
					tx_mark = host_tx_data_i;
					if (tx_mark == host_pkg::MARK_READ)
						tx_left = 1;
					else if (tx_mark == host_pkg::MARK_LOG)
						tx_left = 3;
					else
						report($sformatf("unknown frame marker %02h", host_tx_data_i));
				end
				else
				begin
					tx_left--;
					if (tx_mark == host_pkg::MARK_READ)
					begin
						if (d_q.size() == 0)
							report("D frame byte with no host read pending");
						else
							compare(host_tx_data_i, d_q.pop_front(), "D frame data");
					end
					else if (l_q.size() == 0)
						report("L frame byte with no SPI read pending");
					else
						compare(host_tx_data_i, l_q.pop_front(), "L frame field");
				end
			end

			////////////////////
			// SPI pins
			////////////////////
			if (cs_q && !spi_cs_n_i)
			begin
				bit_n = 0;
				byte_n = 0;
				data_n = 0;
				op = 8'h00;
			end
			// log record expected once a read with data ends
			if (!cs_q && spi_cs_n_i && op == spi_flash_pkg::OP_READ && data_n > 0)
			begin
				l_q.push_back(spi_addr[15:8]);
				l_q.push_back(spi_addr[7:0]);
				l_q.push_back((data_n > 255) ? 8'hFF : 8'(data_n));
			end
			// mode 0, both lines sampled on the rising edge
			if (!spi_cs_n_i && !sclk_q && spi_sclk_i)
			begin
				mbyte = {mosi_sh[6:0], spi_mosi_i};
				sbyte = {miso_sh[6:0], spi_miso_i};
				mosi_sh = mbyte;
				miso_sh = sbyte;
				bit_n++;
				if (bit_n == 8)
				begin
					bit_n = 0;
					if (byte_n == 0)
						op = mbyte;
					else if (op == spi_flash_pkg::OP_JEDEC_ID)
					begin
						if (byte_n <= 3)
							exp = 8'(spi_flash_pkg::JEDEC_ID >> (8 * (3 - byte_n)));
						else
							exp = 8'h00;
						compare(sbyte, exp, $sformatf("JEDEC byte %0d", byte_n - 1));
					end
					else if (op == spi_flash_pkg::OP_READ)
					begin
						if (byte_n <= 3)
							spi_addr = {spi_addr[7:0], mbyte};
						else
						begin
							a = (int'(spi_addr) + data_n) % `FE_MEM_WORDS;
							// bytes never written have no defined value
							if (known[a])
								compare(sbyte, shadow[a], $sformatf("SPI read at %04h", a));
							data_n++;
						end
					end
					byte_n++;
				end
			end
			sclk_q = spi_sclk_i;
			cs_q = spi_cs_n_i;
		end
		pending_o = d_q.size() + l_q.size() + tx_left;
	end

endmodule

/* flash_emu_sva.sv */
// bound checks on the flash emulator top level
// no host transmit valid in reset, valid only with ready
// memory acks only while the matching request is held
`timescale 1ns/100ps

module flash_emu_sva (
	input logic clk,
	input logic reset,
	input logic host_tx_valid_o,
	input logic host_tx_ready_i,
	input logic spi_req,
	input logic spi_ack,
	input logic host_req,
	input logic host_ack
);
	// transmit port stays quiet while reset is held
	assert property (@(posedge clk) reset |-> !host_tx_valid_o)
		else $error("host_tx_valid_o high during reset");

	// merger may only pulse when the host can take the byte
	assert property (@(posedge clk) disable iff (reset) host_tx_valid_o |-> host_tx_ready_i)
		else $error("host_tx_valid_o without host_tx_ready_i");

	// requesters hold req until ack, so an ack alone is a fault
	assert property (@(posedge clk) disable iff (reset) spi_ack |-> spi_req)
		else $error("SPI ack without a pending request");

	assert property (@(posedge clk) disable iff (reset) host_ack |-> host_req)
		else $error("host ack without a pending request");

endmodule

bind flash_emu_top flash_emu_sva sva0 (
	.clk(clk),
	.reset(reset),
	.host_tx_valid_o(host_tx_valid_o),
	.host_tx_ready_i(host_tx_ready_i),
	.spi_req(spi_req),
	.spi_ack(spi_ack),
	.host_req(host_req),
	.host_ack(host_ack)
);

/* tb_flash_emu.sv */
// testbench for the flash emulator
// clock, reset, stimulus table, SPI master and host driver tasks
// watchdog and closing summary
`timescale 1ns/100ps
`include "flash_emu_config.svh"

module tb_flash_emu;
	localparam int NROWS = 10;
	// clk cycles per SCLK phase
	localparam int PHASE = 8;
	localparam int MAX_LEN = 260;
	localparam int DRAIN_CYCLES = 2000;
	// longest SPI row plus drain time
	localparam int ROW_NS = (4 + MAX_LEN) * 8 * 2 * PHASE * 4 + DRAIN_CYCLES * 4;
	localparam int RAND_DATA = -1;

	typedef enum {K_WRITE, K_READ, K_SPI_READ, K_SPI_ID, K_SPI_HOST} kind_e;

	////////////////////
	// stimulus table: kind, address, data or length, tx stall
	////////////////////
	kind_e row_kind [NROWS] = '{K_WRITE, K_READ, K_WRITE, K_WRITE, K_WRITE,
		K_SPI_READ, K_SPI_ID, K_SPI_READ, K_SPI_HOST, K_READ};
	logic [15:0] row_addr [NROWS] = '{16'h1234, 16'h1234, 16'hFFFF, 16'h0000, 16'h0001,
		16'hFFFF, 16'h0000, 16'h1230, 16'h1234, 16'h0000};
	int row_val [NROWS] = '{RAND_DATA, 0, RAND_DATA, RAND_DATA, RAND_DATA,
		3, 5, MAX_LEN, 4, 0};
	bit row_stall [NROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1};

	logic clk = 1'b0;
	logic reset;
	logic spi_cs_n;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_miso;
	logic [7:0] rx_data;
	logic rx_valid;
	logic tx_ready;
	logic [7:0] tx_data;
	logic tx_valid;
	logic quiet;
	int errors;
	int checks;
	int pending;
	bit timed_out = 1'b0;

	always #2 clk = ~clk;

	flash_emu_top dut0 (
		.clk(clk), .reset(reset),
		.spi_cs_n_i(spi_cs_n), .spi_sclk_i(spi_sclk),
		.spi_mosi_i(spi_mosi), .spi_miso_o(spi_miso),
		.host_rx_data_i(rx_data), .host_rx_valid_i(rx_valid),
		.host_tx_ready_i(tx_ready),
		.host_tx_data_o(tx_data), .host_tx_valid_o(tx_valid)
	);

	flash_emu_checker chk0 (
		.clk(clk), .reset(reset), .quiet_i(quiet),
		.spi_cs_n_i(spi_cs_n), .spi_sclk_i(spi_sclk),
		.spi_mosi_i(spi_mosi), .spi_miso_i(spi_miso),
		.host_rx_data_i(rx_data), .host_rx_valid_i(rx_valid),
		.host_tx_data_i(tx_data), .host_tx_valid_i(tx_valid),
		.errors_o(errors), .checks_o(checks), .pending_o(pending)
	);

	// inputs change half a ns after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#0.5;
	endtask

	task automatic host_send(input logic [7:0] b);
		rx_data = b;
		rx_valid = 1'b1;
		step(1);
		rx_valid = 1'b0;
		step(1);
	endtask

	task automatic host_write(input logic [15:0] a, input logic [7:0] d);
		host_send(host_pkg::CMD_WRITE);
		host_send(a[15:8]);
		host_send(a[7:0]);
		host_send(d);
		// parser stays busy until grant and write ack have passed
		step(2);
	endtask

	task automatic host_read(input logic [15:0] a);
		host_send(host_pkg::CMD_READ);
		host_send(a[15:8]);
		host_send(a[7:0]);
	endtask

	// mode 0, MOSI changes with the falling edge
	task automatic spi_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--)
		begin
			spi_mosi = b[i];
			step(PHASE);
			spi_sclk = 1'b1;
			step(PHASE);
			spi_sclk = 1'b0;
		end
	endtask

	task automatic spi_cmd(input logic [7:0] op, input logic [15:0] a, input int n);
		spi_cs_n = 1'b0;
		step(PHASE);
		spi_byte(op);
		if (op == spi_flash_pkg::OP_READ)
		begin
			spi_byte(8'h00);
			spi_byte(a[15:8]);
			spi_byte(a[7:0]);
		end
		repeat (n) spi_byte(8'h00);
		step(PHASE);
		spi_cs_n = 1'b1;
		step(PHASE);
	endtask

	task automatic wait_drained(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < DRAIN_CYCLES; n++)
		begin
			step(1);
			if (pending == 0)
			begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	initial
	begin
		int err_before;
		bit ok;
		void'($urandom(32'haed7_e81a));
		reset = 1'b1;
		spi_cs_n = 1'b1;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		rx_data = 8'h00;
		rx_valid = 1'b0;
		tx_ready = 1'b1;
		quiet = 1'b1;
		step(16);
		reset = 1'b0;
		// outputs must stay idle for a while after reset
		step(20);
		quiet = 1'b0;
		for (int r = 0; r < NROWS; r++)
		begin
			err_before = errors;
			tx_ready = !row_stall[r];
			case (row_kind[r])
				K_WRITE:
					host_write(row_addr[r],
						(row_val[r] == RAND_DATA) ? 8'($urandom) : 8'(row_val[r]));
				K_READ:
					host_read(row_addr[r]);
				K_SPI_READ:
					spi_cmd(spi_flash_pkg::OP_READ, row_addr[r], row_val[r]);
				K_SPI_ID:
					spi_cmd(spi_flash_pkg::OP_JEDEC_ID, 16'h0000, row_val[r]);
				default:
				begin
					// host read lands while chip select is low
					fork
						spi_cmd(spi_flash_pkg::OP_READ, row_addr[r], row_val[r]);
						begin
							step(40);
							host_read(row_addr[r]);
						end
					join
				end
			endcase
			if (row_stall[r])
			begin
				step(60);
				tx_ready = 1'b1;
			end
			wait_drained(ok);
			if (!ok)
			begin
				$display("test %0d: expected host frames never arrived", r);
				timed_out = 1'b1;
				break;
			end
			$display("test %0d %s addr %04h: %s", r, row_kind[r].name(), row_addr[r],
				(errors == err_before) ? "ok" : "mismatch");
		end
		step(20);
		$display("summary: %0d tests, %0d checks, %0d errors, pending %0d",
			NROWS, checks, errors, pending);
		if (errors == 0 && !timed_out && pending == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(NROWS * ROW_NS + 20000);
		$display("watchdog: the run did not finish in the expected time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
spi_flash_pkg.sv
host_pkg.sv
event_fifo.sv
spi_flash_target.sv
host_cmd_parser.sv
shared_flash_mem.sv
host_tx_merge.sv
flash_emu_top.sv
flash_emu_checker.sv
flash_emu_sva.sv
tb_flash_emu.sv

/* run_sim.sh */
#!/bin/bash
# build and run the flash emulator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_flash_emu -o sim_flash_emu \
	&& ./obj_dir/sim_flash_emu > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
